//--- include/fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// cache geometry ---------------

`define FETCH_BLOCK_WORDS    4     // 32-bit words per block.
`define FETCH_BLOCK_HWORDS   8     // halfwords per block.
`define FETCH_INDEX_W        6     // 64 sets.
`define FETCH_WOFS_W         2     // word within block.
`define FETCH_HOFS_W         3     // halfword within block.

// tag is what is left above index, word offset and byte offset
`define FETCH_TAG_W (32 - `FETCH_INDEX_W - `FETCH_WOFS_W - 2)

// bundle -----------------------

`define FETCH_BUNDLE_HWORDS  9     // one block plus the appended halfword.
`define FETCH_CNT_W          4

// axi --------------------------

`define AXI_RESP_OKAY        2'b00

`endif

//--- logic/fetch_pkg.sv
`include "fetch_defines.svh"

package fetch_pkg;

    // controller states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        NEXT_BLOCK,
        REFILL,
        RELOOK
    } fetch_state_t;

    // low two bits both set marks the first half of a 32-bit instruction
    typedef enum logic {
        COMPRESSED,
        FULL_LOW
    } hword_kind_t;

    typedef enum logic [1:0] {
        OKAY = `AXI_RESP_OKAY,
        EXOKAY,
        SLVERR,
        DECERR
    } axi_resp_t;

endpackage : fetch_pkg

//--- logic/icache_array.sv
`timescale 1ns/100ps

`include "fetch_defines.svh"

module icache_array (
    input  logic                                clk_i,
    input  logic                                rst_n_i,

    input  logic                                rd_en_i,
    input  logic [31:0]                         rd_addr_i,

    input  logic                                wr_en_i,
    input  logic                                wr_meta_i,
    input  logic [31:0]                         wr_addr_i,
    input  logic [31:0]                         wr_data_i,

    output logic [`FETCH_BLOCK_HWORDS*16-1:0]   rd_block_o,
    output logic                                hit_o
);

    localparam int BLK_LSB = `FETCH_WOFS_W + 2;
    localparam int SETS    = 2 ** `FETCH_INDEX_W;

    logic [`FETCH_TAG_W-1:0]           tag_mem  [SETS];
    logic [`FETCH_BLOCK_WORDS*32-1:0]  data_mem [SETS];
    logic [SETS-1:0]                   valid_q;

    logic [`FETCH_INDEX_W-1:0] rd_idx;
    logic [`FETCH_INDEX_W-1:0] wr_idx;
    logic [`FETCH_WOFS_W-1:0]  wr_wofs;

    assign rd_idx  = rd_addr_i[BLK_LSB +: `FETCH_INDEX_W];
    assign wr_idx  = wr_addr_i[BLK_LSB +: `FETCH_INDEX_W];
    assign wr_wofs = wr_addr_i[2 +: `FETCH_WOFS_W];

    // storage ----------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (wr_en_i && wr_meta_i) begin
            valid_q[wr_idx] <= 1'b1;                     // first word of a refill.
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            data_mem[wr_idx][wr_wofs*32 +: 32] <= wr_data_i;
            if (wr_meta_i) begin
                tag_mem[wr_idx] <= wr_addr_i[31 -: `FETCH_TAG_W];
            end
        end
    end

    // registered read --------------

    logic [`FETCH_BLOCK_WORDS*32-1:0] rd_block_q;
    logic [`FETCH_TAG_W-1:0]          rd_tag_q;
    logic [`FETCH_TAG_W-1:0]          rd_addr_tag_q;
    logic                             rd_valid_q;

    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_block_q    <= data_mem[rd_idx];
            rd_tag_q      <= tag_mem[rd_idx];
            rd_valid_q    <= valid_q[rd_idx];
            rd_addr_tag_q <= rd_addr_i[31 -: `FETCH_TAG_W];  // tag of the request.
        end
    end

    assign rd_block_o = rd_block_q;
    assign hit_o      = rd_valid_q && (rd_tag_q == rd_addr_tag_q);

    // the controller must never read the set it is filling
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(rd_en_i && wr_en_i && (rd_idx == wr_idx)));

endmodule : icache_array

//--- logic/axi_lite_reader.sv
`timescale 1ns/100ps

module axi_lite_reader (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    input  logic                  load_req_i,
    input  logic [31:0]           load_addr_i,
    output logic                  load_valid_o,
    output logic [31:0]           load_data_o,
    output logic                  load_err_o,

    output logic [31:0]           m_axi_araddr_o,
    output logic                  m_axi_arvalid_o,
    input  logic                  m_axi_arready_i,
    input  logic [31:0]           m_axi_rdata_i,
    input  fetch_pkg::axi_resp_t  m_axi_rresp_i,
    input  logic                  m_axi_rvalid_i,
    output logic                  m_axi_rready_o
);

    import fetch_pkg::*;

    logic        arvalid_q;
    logic        rready_q;
    logic        valid_q;
    logic        err_q;
    logic [31:0] araddr_q;
    logic [31:0] data_q;
    logic        r_done;

    assign r_done = rready_q && m_axi_rvalid_i;

    // AR then R sequence.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            arvalid_q <= 1'b0;
            rready_q  <= 1'b0;
            valid_q   <= 1'b0;
            err_q     <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            err_q   <= 1'b0;
            if (load_req_i) begin
                arvalid_q <= 1'b1;
            end else if (arvalid_q && m_axi_arready_i) begin
                arvalid_q <= 1'b0;
                rready_q  <= 1'b1;                       // read now outstanding.
            end
            if (r_done) begin
                rready_q <= 1'b0;
                valid_q  <= (m_axi_rresp_i == OKAY);
                err_q    <= (m_axi_rresp_i != OKAY);
            end
        end
    end

    // address and holding register.
    always_ff @(posedge clk_i) begin
        if (load_req_i) begin
            araddr_q <= load_addr_i;
        end
        if (r_done) begin
            data_q <= m_axi_rdata_i;                     // kept until next load.
        end
    end

    assign m_axi_araddr_o  = araddr_q;
    assign m_axi_arvalid_o = arvalid_q;
    assign m_axi_rready_o  = rready_q;
    assign load_valid_o    = valid_q;
    assign load_err_o      = err_q;
    assign load_data_o     = data_q;

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        m_axi_arvalid_o && !m_axi_arready_i |=> m_axi_arvalid_o && $stable(m_axi_araddr_o));

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        load_req_i |-> !(arvalid_q || rready_q));

endmodule : axi_lite_reader

//--- logic/fetch_controller.sv
`timescale 1ns/100ps

`include "fetch_defines.svh"

module fetch_controller (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                stall_i,

    input  logic                                fetch_i,
    input  logic [31:0]                         pc_i,
    output logic [`FETCH_BUNDLE_HWORDS*16-1:0]  bundle_o,
    output logic [`FETCH_CNT_W-1:0]             count_o,
    output logic                                valid_o,
    output logic                                misaligned_o,

    output logic                                cache_rd_en_o,
    output logic [31:0]                         cache_rd_addr_o,
    input  logic [`FETCH_BLOCK_HWORDS*16-1:0]   cache_rd_block_i,
    input  logic                                cache_hit_i,
    output logic                                cache_wr_en_o,
    output logic                                cache_wr_meta_o,
    output logic [31:0]                         cache_wr_addr_o,
    output logic [31:0]                         cache_wr_data_o,

    output logic                                load_req_o,
    output logic [31:0]                         load_addr_o,
    input  logic                                load_valid_i,
    input  logic [31:0]                         load_data_i,
    input  logic                                load_err_i
);

    import fetch_pkg::*;

    localparam int BLK_LSB  = `FETCH_WOFS_W + 2;
    localparam int BUNDLE_W = `FETCH_BUNDLE_HWORDS * 16;
    localparam int CNT_W    = `FETCH_CNT_W;
    localparam int LAST_HW  = `FETCH_BLOCK_HWORDS - 1;

    function automatic hword_kind_t hword_kind(input logic [15:0] hw);
        return (hw[1:0] == 2'b11) ? FULL_LOW : COMPRESSED;
    endfunction

    // state ------------------------

    fetch_state_t              state_q, state_d;
    logic [31:0]               pc_q, pc_d;
    logic [BUNDLE_W-1:0]       bundle_q, bundle_d;
    logic [CNT_W-1:0]          cnt_q, cnt_d;
    logic                      mis_q, mis_d;
    logic                      valid_q, valid_d;
    logic [`FETCH_WOFS_W-1:0]  word_q, word_d;
    logic                      wait_q, wait_d;       // word load outstanding.
    logic                      fill_next_q, fill_next_d;
    logic                      load_seen_q, err_seen_q;

    logic                      rd_en, wr_en, load_req, consume;
    logic [31:0]               rd_addr;
    logic [`FETCH_HOFS_W-1:0]  hofs;
    logic [31-BLK_LSB:0]       next_blk, fill_blk;
    logic                      load_done, err_done;

    assign hofs      = pc_q[`FETCH_HOFS_W:1];
    assign next_blk  = pc_q[31:BLK_LSB] + 1'b1;      // carries into the tag.
    assign fill_blk  = fill_next_q ? next_blk : pc_q[31:BLK_LSB];
    assign load_done = load_valid_i || load_seen_q;
    assign err_done  = load_err_i || err_seen_q;

    always_comb begin
        state_d     = state_q;
        pc_d        = pc_q;
        bundle_d    = bundle_q;
        cnt_d       = cnt_q;
        mis_d       = mis_q;
        valid_d     = 1'b0;
        word_d      = word_q;
        wait_d      = wait_q;
        fill_next_d = fill_next_q;
        rd_en       = 1'b0;
        rd_addr     = pc_q;
        wr_en       = 1'b0;
        load_req    = 1'b0;
        consume     = 1'b0;

        case (state_q)
            IDLE: begin
                rd_addr = pc_i;
                if (fetch_i) begin
                    rd_en   = 1'b1;
                    pc_d    = pc_i;
                    state_d = LOOKUP;
                end
            end

            LOOKUP: begin
                if (cache_hit_i) begin
                    // drop the halfwords below the pc.
                    bundle_d = {16'b0, cache_rd_block_i} >> {hofs, 4'b0};
                    cnt_d    = CNT_W'(`FETCH_BLOCK_HWORDS) - CNT_W'(hofs);
                    if (hword_kind(cache_rd_block_i[LAST_HW*16 +: 16]) == FULL_LOW &&
                        hword_kind(cache_rd_block_i[(LAST_HW-1)*16 +: 16]) == COMPRESSED) begin
                        mis_d   = 1'b1;
                        rd_en   = 1'b1;
                        rd_addr = {next_blk, {BLK_LSB{1'b0}}};
                        state_d = NEXT_BLOCK;
                    end else begin
                        mis_d   = 1'b0;
                        valid_d = 1'b1;
                        state_d = IDLE;
                    end
                end else begin
                    mis_d       = 1'b0;
                    fill_next_d = 1'b0;
                    word_d      = '0;
                    wait_d      = 1'b0;
                    state_d     = REFILL;
                end
            end

            NEXT_BLOCK: begin
                if (cache_hit_i) begin
                    // first halfword of the next block goes above the kept ones.
                    bundle_d = bundle_q |
                               (BUNDLE_W'(cache_rd_block_i[15:0]) << {cnt_q, 4'b0});
                    cnt_d    = cnt_q + 1'b1;
                    valid_d  = 1'b1;
                    state_d  = IDLE;
                end else begin
                    fill_next_d = 1'b1;
                    word_d      = '0;
                    wait_d      = 1'b0;
                    state_d     = REFILL;
                end
            end

            REFILL: begin
                if (!wait_q) begin
                    load_req = 1'b1;
                    wait_d   = 1'b1;
                end else if (err_done) begin
                    consume  = 1'b1;
                    bundle_d = '0;                   // empty bundle marks the error.
                    cnt_d    = '0;
                    mis_d    = 1'b0;
                    valid_d  = 1'b1;
                    state_d  = IDLE;
                end else if (load_done) begin
                    consume = 1'b1;
                    wr_en   = 1'b1;
                    wait_d  = 1'b0;
                    word_d  = word_q + 1'b1;
                    if (word_q == '1) begin
                        state_d = RELOOK;
                    end
                end
            end

            RELOOK: begin
                rd_en   = 1'b1;
                rd_addr = fill_next_q ? {next_blk, {BLK_LSB{1'b0}}} : pc_q;
                state_d = fill_next_q ? NEXT_BLOCK : LOOKUP;
            end

            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q     <= IDLE;
            valid_q     <= 1'b0;
            word_q      <= '0;
            wait_q      <= 1'b0;
            fill_next_q <= 1'b0;
        end else if (!stall_i) begin
            state_q     <= state_d;
            valid_q     <= valid_d;
            word_q      <= word_d;
            wait_q      <= wait_d;
            fill_next_q <= fill_next_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            pc_q     <= pc_d;
            bundle_q <= bundle_d;
            cnt_q    <= cnt_d;
            mis_q    <= mis_d;
        end
    end

    // reader pulses arriving during a stall are remembered here
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            load_seen_q <= 1'b0;
            err_seen_q  <= 1'b0;
        end else begin
            load_seen_q <= (load_seen_q || load_valid_i) && !(consume && !stall_i);
            err_seen_q  <= (err_seen_q || load_err_i) && !(consume && !stall_i);
        end
    end

    // outputs ----------------------

    assign bundle_o        = bundle_q;
    assign count_o         = cnt_q;
    assign misaligned_o    = mis_q;
    assign valid_o         = valid_q && !stall_i;

    assign cache_rd_en_o   = rd_en && !stall_i;
    assign cache_rd_addr_o = rd_addr;
    assign cache_wr_en_o   = wr_en && !stall_i;
    assign cache_wr_meta_o = (word_q == '0);         // tag and valid with word 0.
    assign cache_wr_addr_o = {fill_blk, word_q, 2'b00};
    assign cache_wr_data_o = load_data_i;

    assign load_req_o      = load_req && !stall_i;
    assign load_addr_o     = {fill_blk, word_q, 2'b00};

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(valid_o && cache_wr_en_o));

    // a new word load starts only once the last one has been taken
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        load_req_o |-> state_q == REFILL && !load_seen_q && !err_seen_q);

endmodule : fetch_controller

//--- logic/fetch_unit.sv
`timescale 1ns/100ps

`include "fetch_defines.svh"

module fetch_unit (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                stall_i,

    input  logic                                fetch_i,
    input  logic [31:0]                         pc_i,
    output logic [`FETCH_BUNDLE_HWORDS*16-1:0]  bundle_o,
    output logic [`FETCH_CNT_W-1:0]             count_o,
    output logic                                valid_o,
    output logic                                misaligned_o,

    output logic [31:0]                         m_axi_araddr_o,
    output logic                                m_axi_arvalid_o,
    input  logic                                m_axi_arready_i,
    input  logic [31:0]                         m_axi_rdata_i,
    input  fetch_pkg::axi_resp_t                m_axi_rresp_i,
    input  logic                                m_axi_rvalid_i,
    output logic                                m_axi_rready_o
);

    // controller to cache ----------

    logic                               cache_rd_en;
    logic [31:0]                        cache_rd_addr;
    logic [`FETCH_BLOCK_HWORDS*16-1:0]  cache_rd_block;
    logic                               cache_hit;
    logic                               cache_wr_en;
    logic                               cache_wr_meta;
    logic [31:0]                        cache_wr_addr;
    logic [31:0]                        cache_wr_data;

    // controller to reader ---------

    logic        load_req;
    logic [31:0] load_addr;
    logic        load_valid;
    logic [31:0] load_data;
    logic        load_err;

    fetch_controller fetch_controller_inst (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .stall_i          (stall_i),
        .fetch_i          (fetch_i),
        .pc_i             (pc_i),
        .bundle_o         (bundle_o),
        .count_o          (count_o),
        .valid_o          (valid_o),
        .misaligned_o     (misaligned_o),
        .cache_rd_en_o    (cache_rd_en),
        .cache_rd_addr_o  (cache_rd_addr),
        .cache_rd_block_i (cache_rd_block),
        .cache_hit_i      (cache_hit),
        .cache_wr_en_o    (cache_wr_en),
        .cache_wr_meta_o  (cache_wr_meta),
        .cache_wr_addr_o  (cache_wr_addr),
        .cache_wr_data_o  (cache_wr_data),
        .load_req_o       (load_req),
        .load_addr_o      (load_addr),
        .load_valid_i     (load_valid),
        .load_data_i      (load_data),
        .load_err_i       (load_err)
    );

    icache_array icache_array_inst (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rd_en_i    (cache_rd_en),
        .rd_addr_i  (cache_rd_addr),
        .wr_en_i    (cache_wr_en),
        .wr_meta_i  (cache_wr_meta),
        .wr_addr_i  (cache_wr_addr),
        .wr_data_i  (cache_wr_data),
        .rd_block_o (cache_rd_block),
        .hit_o      (cache_hit)
    );

    axi_lite_reader axi_lite_reader_inst (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .load_req_i      (load_req),
        .load_addr_i     (load_addr),
        .load_valid_o    (load_valid),
        .load_data_o     (load_data),
        .load_err_o      (load_err),
        .m_axi_araddr_o  (m_axi_araddr_o),
        .m_axi_arvalid_o (m_axi_arvalid_o),
        .m_axi_arready_i (m_axi_arready_i),
        .m_axi_rdata_i   (m_axi_rdata_i),
        .m_axi_rresp_i   (m_axi_rresp_i),
        .m_axi_rvalid_i  (m_axi_rvalid_i),
        .m_axi_rready_o  (m_axi_rready_o)
    );

endmodule : fetch_unit

//--- tb/fetch_checker.sv
`timescale 1ns/100ps

`include "fetch_defines.svh"

module fetch_checker (
    input  logic                                clk_i,
    input  logic                                fetch_i,
    input  logic                                valid_i,
    input  logic [`FETCH_BUNDLE_HWORDS*16-1:0]  bundle_i,
    input  logic [`FETCH_CNT_W-1:0]             count_i,
    input  logic                                misaligned_i
);

    // expected results in fetch order ----

    logic [`FETCH_BUNDLE_HWORDS*16-1:0] exp_bundle_q [$];
    logic [`FETCH_CNT_W-1:0]            exp_count_q  [$];
    logic                               exp_mis_q    [$];
    int                                 exp_lat_q    [$];

    int error_count = 0;
    int check_count = 0;
    int lat_cycles  = 0;                 // falling edges since the request was seen.

    task automatic push_expected(input logic [`FETCH_BUNDLE_HWORDS*16-1:0] bundle,
                                 input logic [`FETCH_CNT_W-1:0] count,
                                 input logic mis,
                                 input int lat);
        exp_bundle_q.push_back(bundle);
        exp_count_q.push_back(count);
        exp_mis_q.push_back(mis);
        exp_lat_q.push_back(lat);
    endtask

    function automatic int pending();
        return exp_bundle_q.size();
    endfunction

    // outputs are settled at the falling edge.
    always @(negedge clk_i) begin : compare
        logic [`FETCH_BUNDLE_HWORDS*16-1:0] eb;
        logic [`FETCH_CNT_W-1:0]            ec;
        logic                               em;
        int                                 el;
        if (fetch_i) begin
            lat_cycles = 0;
        end else begin
            lat_cycles++;
        end
        if (valid_i) begin
            if (exp_bundle_q.size() == 0) begin
                error_count++;
                $display("valid_o pulsed at %0t with no fetch outstanding", $time);
            end else begin
                eb = exp_bundle_q.pop_front();
                ec = exp_count_q.pop_front();
                em = exp_mis_q.pop_front();
                el = exp_lat_q.pop_front();
                check_count++;
                if (count_i !== ec) begin
                    error_count++;
                    $display("mismatch count_o: got %h expected %h", count_i, ec);
                end
                if (misaligned_i !== em) begin
                    error_count++;
                    $display("mismatch misaligned_o: got %h expected %h", misaligned_i, em);
                end
                if (bundle_i !== eb) begin
                    error_count++;
                    $display("mismatch bundle_o: got %h expected %h", bundle_i, eb);
                end
                if (el != 0 && lat_cycles != el) begin
                    error_count++;
                    $display("mismatch valid_o latency: got %h expected %h", lat_cycles, el);
                end
            end
        end
    end

endmodule : fetch_checker

//--- tb/fetch_unit_tb.sv
`timescale 1ns/100ps

`include "fetch_defines.svh"

module fetch_unit_tb;

    import fetch_pkg::*;

    localparam int BUNDLE_W  = `FETCH_BUNDLE_HWORDS * 16;
    localparam int MEM_WORDS = 256;

    logic                   clk_i;
    logic                   rst_n_i;
    logic                   stall_i;
    logic                   fetch_i;
    logic [31:0]            pc_i;
    logic [BUNDLE_W-1:0]    bundle_o;
    logic [`FETCH_CNT_W-1:0] count_o;
    logic                   valid_o;
    logic                   misaligned_o;
    logic [31:0]            m_axi_araddr_o;
    logic                   m_axi_arvalid_o;
    logic                   m_axi_arready_i;
    logic [31:0]            m_axi_rdata_i;
    axi_resp_t              m_axi_rresp_i;
    logic                   m_axi_rvalid_i;
    logic                   m_axi_rready_o;

    logic [31:0]            mem [MEM_WORDS];
    logic [31:0]            rec_pc     [$];
    int                     rec_stall  [$];
    int                     rec_lat    [$];
    logic [`FETCH_CNT_W-1:0] rec_cnt   [$];
    logic                   rec_mis    [$];
    logic [BUNDLE_W-1:0]    rec_bundle [$];

    int tb_errors = 0;
    int limit     = 0;
    int cycle_cnt = 0;

    fetch_unit fetch_unit_inst (.*);

    fetch_checker fetch_checker_inst (
        .clk_i        (clk_i),
        .fetch_i      (fetch_i),
        .valid_i      (valid_o),
        .bundle_i     (bundle_o),
        .count_i      (count_o),
        .misaligned_i (misaligned_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // stimulus file ----------------

    task automatic load_stimulus();
        int          fd;
        int          n;
        int          words;
        string       line;
        logic [31:0] w [14];
        logic [BUNDLE_W-1:0] b;
        fd = $fopen("tb/fetch_stimulus.txt", "r");
        if (fd == 0) begin
            tb_errors++;
            $display("could not open tb/fetch_stimulus.txt");
            return;
        end
        words = 0;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") continue;
            if (words < MEM_WORDS) begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                            w[0], w[1], w[2], w[3], w[4], w[5], w[6], w[7]);
                for (int k = 0; k < n; k++) mem[words + k] = w[k];
                words += n;
            end else begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            w[0], w[1], w[2], w[3], w[4], w[5], w[6], w[7],
                            w[8], w[9], w[10], w[11], w[12], w[13]);
                if (n != 14) begin
                    tb_errors++;
                    $display("badly formed fetch record in stimulus file");
                end else begin
                    b = '0;
                    for (int k = 0; k < `FETCH_BUNDLE_HWORDS; k++) b[k*16 +: 16] = w[5+k][15:0];
                    rec_pc.push_back(w[0]);
                    rec_stall.push_back(int'(w[1]));
                    rec_lat.push_back(int'(w[2]));
                    rec_cnt.push_back(w[3][`FETCH_CNT_W-1:0]);
                    rec_mis.push_back(w[4][0]);
                    rec_bundle.push_back(b);
                end
            end
        end
        $fclose(fd);
    endtask

    // one fetch up to its valid_o --

    task automatic run_fetch(input int idx);
        @(posedge clk_i);
        #2;
        fetch_i = 1'b1;
        pc_i    = rec_pc[idx];
        fetch_checker_inst.push_expected(rec_bundle[idx], rec_cnt[idx], rec_mis[idx],
                                         rec_lat[idx]);
        @(posedge clk_i);                                // accepted here.
        #2;
        fetch_i = 1'b0;
        if (rec_stall[idx] == 1) begin
            stall_i = 1'b1;                              // freeze the lookup.
            repeat (3) @(posedge clk_i);
            #2 stall_i = 1'b0;
        end else if (rec_stall[idx] == 2) begin
            do @(negedge clk_i); while (!m_axi_arvalid_o);
            @(posedge clk_i);
            #2 stall_i = 1'b1;                           // freeze mid refill.
            repeat (4) @(posedge clk_i);
            #2 stall_i = 1'b0;
        end
        do @(negedge clk_i); while (!valid_o);
    endtask

    function automatic int total_errors();
        return tb_errors + fetch_checker_inst.error_count;
    endfunction

    task automatic print_counts();
        $display("fetches %0d, checked %0d, errors %0d", rec_pc.size(),
                 fetch_checker_inst.check_count, total_errors());
    endtask

    initial begin : stimulus
        rst_n_i = 1'b0;
        stall_i = 1'b0;
        fetch_i = 1'b0;
        pc_i    = '0;
        load_stimulus();
        limit = 200 * rec_pc.size() + 100;
        repeat (10) @(posedge clk_i);
        #2 rst_n_i = 1'b1;
        for (int i = 0; i < rec_pc.size(); i++) run_fetch(i);
        repeat (10) @(posedge clk_i);                    // catch any extra valid_o.
        if (fetch_checker_inst.pending() != 0) begin
            tb_errors++;
            $display("a fetch ended without a valid_o pulse");
        end
        print_counts();
        if (total_errors() == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin : watchdog
        wait (limit != 0);
        while (cycle_cnt < limit) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, %0d fetch(es) still without valid_o",
                 cycle_cnt, fetch_checker_inst.pending());
        print_counts();
        $display("Regression failed");
        $finish;
    end

    // AXI4-Lite memory -------------

    initial begin : axi_memory
        logic [31:0] addr;
        int          delay;
        void'($urandom(32'h9ffd));
        m_axi_arready_i = 1'b0;
        m_axi_rvalid_i  = 1'b0;
        m_axi_rdata_i   = '0;
        m_axi_rresp_i   = OKAY;
        forever begin
            @(negedge clk_i);
            if (m_axi_arvalid_o === 1'b1) begin
                addr  = m_axi_araddr_o;
                delay = int'($urandom % 4);
                repeat (delay) @(posedge clk_i);
                @(posedge clk_i);
                #2 m_axi_arready_i = 1'b1;
                @(posedge clk_i);                        // address handshake.
                #2 m_axi_arready_i = 1'b0;
                delay = int'($urandom % 4);
                repeat (delay) @(posedge clk_i);
                #2;
                m_axi_rvalid_i = 1'b1;
                if (addr < MEM_WORDS * 4) begin
                    m_axi_rdata_i = mem[addr[9:2]];
                    m_axi_rresp_i = OKAY;
                end else begin
                    m_axi_rdata_i = '0;
                    m_axi_rresp_i = SLVERR;              // beyond the image.
                end
                do @(negedge clk_i); while (!m_axi_rready_o);
                @(posedge clk_i);
                #2 m_axi_rvalid_i = 1'b0;
            end
        end
    end

endmodule : fetch_unit_tb

//--- tb/fetch_stimulus.txt
# memory image: 256 words in hex, word address 0 first, eight words per line
00040000 000C0008 00140010 001C0018 00240020 002C0028 00340030 003C0038
00440040 004C0048 00540050 005F0058 00640060 006C0068 00740070 007C0078
00840080 008C0088 00940090 009C0098 00A400A0 00AC00A8 00B400B0 00BF00B8
00C400C0 00CC00C8 00D400D0 00DC00D8 00E400E0 00EC00E8 00F400F0 00FC00F8
01040100 010C0108 01140110 011C0118 01240120 012C0128 01340130 013C0138
01440140 014C0148 01540150 015C0158 01640160 016C0168 01740170 017C0178
01840180 018C0188 01940190 019C0198 01A401A0 01AC01A8 01B401B0 01BC01B8
01C401C0 01CC01C8 01D401D0 01DC01D8 01E401E0 01EC01E8 01F401F0 01FC01F8
02040200 020C0208 02140210 021C0218 02240220 022C0228 02340230 023C0238
02440240 024C0248 02540250 025C0258 02640260 026C0268 02740270 027C0278
02840280 028C0288 02940290 029C0298 02A402A0 02AC02A8 02B402B0 02BC02B8
02C402C0 02CC02C8 02D402D0 02DC02D8 02E402E0 02EC02E8 02F402F0 02FC02F8
03040300 030C0308 03140310 031C0318 03240320 032C0328 03340330 033C0338
03440340 034C0348 03540350 035C0358 03640360 036C0368 03740370 037C0378
03840380 038C0388 03940390 039C0398 03A403A0 03AC03A8 03B403B0 03BC03B8
03C403C0 03CC03C8 03D403D0 03DC03D8 03E403E0 03EC03E8 03F403F0 03FC03F8
04040400 040C0408 04140410 041C0418 04240420 042C0428 04340430 043C0438
04440440 044C0448 04540450 045C0458 04640460 046C0468 04740470 047C0478
04840480 048C0488 04940490 049C0498 04A404A0 04AC04A8 04B404B0 04BC04B8
04C404C0 04CC04C8 04D404D0 04DC04D8 04E404E0 04EC04E8 04F404F0 04FC04F8
05040500 050C0508 05140510 051C0518 05240520 052C0528 05340530 053C0538
05440540 054C0548 05540550 055C0558 05640560 056C0568 05740570 057C0578
05840580 058C0588 05940590 059C0598 05A405A0 05AC05A8 05B405B0 05BC05B8
05C405C0 05CC05C8 05D405D0 05DC05D8 05E405E0 05EC05E8 05F405F0 05FC05F8
06040600 060C0608 06140610 061C0618 06240620 062C0628 06340630 063C0638
06440640 064C0648 06540650 065C0658 06640660 066C0668 06740670 067C0678
06840680 068C0688 06940690 069C0698 06A406A0 06AC06A8 06B406B0 06BC06B8
06C406C0 06CC06C8 06D406D0 06DC06D8 06E406E0 06EC06E8 06F406F0 06FC06F8
07040700 070C0708 07140710 071C0718 07240720 072C0728 07340730 073C0738
07440740 074C0748 07540750 075C0758 07640760 076C0768 07740770 077C0778
07840780 078C0788 07940790 079C0798 07A407A0 07AC07A8 07B407B0 07BC07B8
07C407C0 07CC07C8 07D407D0 07DC07D8 07E407E0 07EC07E8 07F407F0 07FC07F8
# fetch records: pc stall latency count misaligned h0 h1 h2 h3 h4 h5 h6 h7 h8 (hex)
# stall 0 none, 1 during lookup, 2 during refill; latency 0 means not checked
00000104 0 0 6 0 0208 020C 0210 0214 0218 021C 0000 0000 0000
00000104 0 2 6 0 0208 020C 0210 0214 0218 021C 0000 0000 0000
00000100 0 2 8 0 0200 0204 0208 020C 0210 0214 0218 021C 0000
00000030 0 0 8 0 0060 0064 0068 006C 0070 0074 0078 007C 0000
0000002A 0 0 4 1 0054 0058 005F 0060 0000 0000 0000 0000 0000
0000002A 0 3 4 1 0054 0058 005F 0060 0000 0000 0000 0000 0000
00000050 2 0 9 1 00A0 00A4 00A8 00AC 00B0 00B4 00B8 00BF 00C0
00000050 0 3 9 1 00A0 00A4 00A8 00AC 00B0 00B4 00B8 00BF 00C0
00000104 1 0 6 0 0208 020C 0210 0214 0218 021C 0000 0000 0000
00000400 0 0 0 0 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000000C 0 0 2 0 0018 001C 0000 0000 0000 0000 0000 0000 0000
000003FC 0 0 2 0 07F8 07FC 0000 0000 0000 0000 0000 0000 0000

//--- sim.f
+incdir+include
logic/fetch_pkg.sv
logic/icache_array.sv
logic/axi_lite_reader.sv
logic/fetch_controller.sv
logic/fetch_unit.sv
tb/fetch_checker.sv
tb/fetch_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the fetch unit testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module fetch_unit_tb -o fetch_unit_sim

./obj_dir/fetch_unit_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi
if ! grep -q "Regression passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
